//--- dcache_top.f
hw/dcache_pkg.sv
hw/dcache_tags.sv
hw/dcache_data.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
testbench/dcache_checker.sv
testbench/tb_dcache.sv

//--- hw/dcache_ctrl.sv
module dcache_ctrl (
   input  logic               CLK,
   input  logic               nRST,
   input  logic               dmem_ren,
   input  logic               dmem_wen,
   input  logic               halt,
   input  dcache_pkg::word_t  dmem_addr,
   input  dcache_pkg::word_t  dmem_store,
   output logic               dhit,
   output logic               flushed,
   output logic               mem_ren,
   output logic               mem_wen,
   output dcache_pkg::word_t  mem_addr,
   output dcache_pkg::word_t  mem_store,
   input  dcache_pkg::word_t  mem_load,
   input  logic               mem_wait,
   output dcache_pkg::index_t tag_index,
   output dcache_pkg::tag_t   req_tag,
   output logic               sel_way,
   output logic               tag_we,
   output logic               new_valid,
   output logic               new_dirty,
   output logic               lru_we,
   output logic               new_lru,
   input  logic               hit,
   input  logic               hit_way,
   input  logic               lru_way,
   input  dcache_pkg::tag_t   sel_tag,
   input  logic               sel_valid,
   input  logic               sel_dirty,
   output logic               data_way,
   output logic               word_sel,
   output logic               data_we,
   output dcache_pkg::word_t  data_wdata,
   input  dcache_pkg::word_t  data_rdata
);
   import dcache_pkg::*;

   cache_state_t state, next_state;
   slot_t        slot, next_slot;
   logic         req;
   logic         flushing;
   logic         done;
   index_t       req_index;

   // block word address from tag, set and word offset
   function automatic word_t blk_addr(tag_t t, index_t i, logic w);
      blk_addr = {t, i, w, 2'b00};
   endfunction

   assign req       = dmem_ren | dmem_wen;
   assign req_index = dmem_addr[TAG_LSB-1:INDEX_LSB];
   assign flushing  = (state == FLUSH_SCAN) || (state == FLUSH1) || (state == FLUSH2);
   // memory transfer finishes this edge
   assign done      = ~mem_wait;

   // during the walk the slot counter names the set and way
   assign tag_index = flushing ? index_t'(slot[2:0]) : req_index;
   // flush rewrites the slot's own tag when it clears dirty
   assign req_tag   = flushing ? sel_tag : dmem_addr[31:TAG_LSB];
   assign sel_way   = flushing ? slot[3] : ((state == IDLE && hit) ? hit_way : lru_way);
   assign data_way  = sel_way;
   assign flushed   = (state == HALTED);

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         state <= IDLE;
         slot  <= '0;
      end
      else
      begin
         state <= next_state;
         slot  <= next_slot;
      end
   end

   always_comb
   begin
      next_state = state;
      next_slot  = slot;
      dhit       = 1'b0;
      mem_ren    = 1'b0;
      mem_wen    = 1'b0;
      mem_addr   = '0;
      mem_store  = '0;
      tag_we     = 1'b0;
      new_valid  = 1'b1;
      new_dirty  = 1'b0;
      lru_we     = 1'b0;
      new_lru    = hit_way;
      word_sel   = dmem_addr[WORD_SEL_BIT];
      data_we    = 1'b0;
      data_wdata = dmem_store;
      case (state)
         IDLE:
         begin
            // hits answer this cycle, store and LRU land at the edge
            if (req && hit)
            begin
               dhit   = 1'b1;
               lru_we = 1'b1;
               if (dmem_wen)
               begin
                  tag_we    = 1'b1;
                  new_dirty = 1'b1;
                  data_we   = 1'b1;
               end
            end
            // miss, sel_* shows the LRU victim here
            if (req && !hit)
            begin
               next_state = (sel_valid && sel_dirty) ? WB1 : READ1;
            end
            else if (halt)
            begin
               next_state = FLUSH_SCAN;
               next_slot  = '0;
            end
         end
         WB1, WB2, FLUSH1, FLUSH2:
         begin
            // victim block out, word 0 then word 1
            word_sel  = (state == WB2) || (state == FLUSH2);
            mem_wen   = 1'b1;
            mem_addr  = blk_addr(sel_tag, tag_index, word_sel);
            mem_store = data_rdata;
            if (done)
            begin
               case (state)
                  WB1:     next_state = WB2;
                  WB2:     next_state = READ1;
                  FLUSH1:  next_state = FLUSH2;
                  default:
                  begin
                     // slot written back, clear its dirty bit and move on
                     tag_we    = 1'b1;
                     next_slot = slot + 1'b1;
                     next_state = (slot == slot_t'(FLUSH_SLOTS - 1)) ? HALTED : FLUSH_SCAN;
                  end
               endcase
            end
         end
         READ1, READ2:
         begin
            // fill into the victim way
            word_sel   = (state == READ2);
            mem_ren    = 1'b1;
            mem_addr   = blk_addr(req_tag, req_index, word_sel);
            data_wdata = mem_load;
            data_we    = done;
            if (done && state == READ1)
            begin
               next_state = READ2;
            end
            else if (done)
            begin
               // block complete, write-allocate marks it dirty up front
               tag_we     = 1'b1;
               new_dirty  = dmem_wen;
               lru_we     = 1'b1;
               new_lru    = lru_way;
               next_state = IDLE;
            end
         end
         FLUSH_SCAN:
         begin
            // one cycle per slot, dirty slots detour through FLUSH1/FLUSH2
            if (sel_valid && sel_dirty)
            begin
               next_state = FLUSH1;
            end
            else
            begin
               next_slot  = slot + 1'b1;
               next_state = (slot == slot_t'(FLUSH_SLOTS - 1)) ? HALTED : FLUSH_SCAN;
            end
         end
         default:
         begin
            // halted for good
            next_state = HALTED;
         end
      endcase
   end

endmodule

//--- hw/dcache_data.sv
module dcache_data (
   input  logic               CLK,
   input  dcache_pkg::index_t index,
   input  logic               way,
   input  logic               word_sel,
   input  logic               we,
   input  dcache_pkg::word_t  wdata,
   output dcache_pkg::word_t  rdata
);
   import dcache_pkg::*;

   // two words per block, one block per way per set
   word_t mem_arr [NUM_WAYS][NUM_SETS][2];

   // read path
   // feeds the processor load and the write-back store
   assign rdata = mem_arr[way][index][word_sel];

   // single word write
   // store hits, fill words and nothing else
   always_ff @(posedge CLK)
   begin
      if (we)
      begin
         mem_arr[way][index][word_sel] <= wdata;
      end
   end

endmodule

//--- hw/dcache_pkg.sv
package dcache_pkg;

   // data word, also used for byte addresses
   typedef logic [31:0] word_t;

   // address tag, bits 31 to 6
   typedef logic [25:0] tag_t;

   // set index, bits 5 to 3
   typedef logic [2:0] index_t;

   // address layout
   localparam int TAG_LSB      = 6;
   localparam int INDEX_LSB    = 3;
   // picks word 0 or word 1 of a block
   localparam int WORD_SEL_BIT = 2;

   // geometry
   localparam int NUM_SETS    = 8;
   localparam int NUM_WAYS    = 2;
   // one flush step per way per set
   localparam int FLUSH_SLOTS = 16;

   // flush walk counter
   // top bit is the way, low bits are the set
   typedef logic [3:0] slot_t;

   // controller states
   typedef enum logic [3:0]
   {
      IDLE,
      WB1,
      WB2,
      READ1,
      READ2,
      FLUSH_SCAN,
      FLUSH1,
      FLUSH2,
      HALTED
   } cache_state_t;

endpackage

//--- hw/dcache_tags.sv
module dcache_tags (
   input  logic               CLK,
   input  logic               nRST,
   input  dcache_pkg::index_t index,
   input  dcache_pkg::tag_t   tag,
   output logic               hit,
   output logic               hit_way,
   output logic               lru_way,
   input  logic               sel_way,
   output dcache_pkg::tag_t   sel_tag,
   output logic               sel_valid,
   output logic               sel_dirty,
   input  logic               tag_we,
   input  logic               new_valid,
   input  logic               new_dirty,
   input  logic               lru_we,
   input  logic               new_lru
);
   import dcache_pkg::*;

   // tag array per way, guarded by the valid bits
   tag_t tag_arr [NUM_WAYS][NUM_SETS];

   // state bits per way, one bit per set
   logic [NUM_SETS-1:0] valid_arr [NUM_WAYS];
   logic [NUM_SETS-1:0] dirty_arr [NUM_WAYS];

   // most recently used way of each set
   logic [NUM_SETS-1:0] lru_bits;

   // per-way tag match for the indexed set
   logic [NUM_WAYS-1:0] match;

   always_comb
   begin
      for (int w = 0; w < NUM_WAYS; w++)
      begin
         match[w] = valid_arr[w][index] && (tag_arr[w][index] == tag);
      end
   end

   // a block lives in at most one way, so way 1 matching names the way
   assign hit     = |match;
   assign hit_way = match[1];

   // victim is the way not used last
   assign lru_way = ~lru_bits[index];

   // victim or flush slot view
   assign sel_tag   = tag_arr[sel_way][index];
   assign sel_valid = valid_arr[sel_way][index];
   assign sel_dirty = dirty_arr[sel_way][index];

   // tag payload
   always_ff @(posedge CLK)
   begin
      if (tag_we)
      begin
         tag_arr[sel_way][index] <= tag;
      end
   end

   // control bits
   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         for (int w = 0; w < NUM_WAYS; w++)
         begin
            valid_arr[w] <= '0;
            dirty_arr[w] <= '0;
         end
         lru_bits <= '0;
      end
      else
      begin
         if (tag_we)
         begin
            valid_arr[sel_way][index] <= new_valid;
            dirty_arr[sel_way][index] <= new_dirty;
         end
         if (lru_we)
         begin
            lru_bits[index] <= new_lru;
         end
      end
   end

endmodule

//--- hw/dcache_top.sv
module dcache_top (
   input  logic              CLK,
   input  logic              nRST,
   input  logic              dmem_ren,
   input  logic              dmem_wen,
   input  logic              halt,
   input  dcache_pkg::word_t dmem_addr,
   input  dcache_pkg::word_t dmem_store,
   output dcache_pkg::word_t dmem_load,
   output logic              dhit,
   output logic              flushed,
   output logic              mem_ren,
   output logic              mem_wen,
   output dcache_pkg::word_t mem_addr,
   output dcache_pkg::word_t mem_store,
   input  dcache_pkg::word_t mem_load,
   input  logic              mem_wait
);
   import dcache_pkg::*;

   // controller to tag store
   index_t tag_index;
   tag_t   req_tag;
   logic   sel_way;
   logic   tag_we;
   logic   new_valid;
   logic   new_dirty;
   logic   lru_we;
   logic   new_lru;

   // tag store to controller
   logic   hit;
   logic   hit_way;
   logic   lru_way;
   tag_t   sel_tag;
   logic   sel_valid;
   logic   sel_dirty;

   // controller to data store
   logic   data_way;
   logic   word_sel;
   logic   data_we;
   word_t  data_wdata;
   word_t  data_rdata;

   // processor load comes straight off the data read mux
   assign dmem_load = data_rdata;

   dcache_ctrl ctrl0 (
      .CLK        (CLK),
      .nRST       (nRST),
      .dmem_ren   (dmem_ren),
      .dmem_wen   (dmem_wen),
      .halt       (halt),
      .dmem_addr  (dmem_addr),
      .dmem_store (dmem_store),
      .dhit       (dhit),
      .flushed    (flushed),
      .mem_ren    (mem_ren),
      .mem_wen    (mem_wen),
      .mem_addr   (mem_addr),
      .mem_store  (mem_store),
      .mem_load   (mem_load),
      .mem_wait   (mem_wait),
      .tag_index  (tag_index),
      .req_tag    (req_tag),
      .sel_way    (sel_way),
      .tag_we     (tag_we),
      .new_valid  (new_valid),
      .new_dirty  (new_dirty),
      .lru_we     (lru_we),
      .new_lru    (new_lru),
      .hit        (hit),
      .hit_way    (hit_way),
      .lru_way    (lru_way),
      .sel_tag    (sel_tag),
      .sel_valid  (sel_valid),
      .sel_dirty  (sel_dirty),
      .data_way   (data_way),
      .word_sel   (word_sel),
      .data_we    (data_we),
      .data_wdata (data_wdata),
      .data_rdata (data_rdata)
   );

   dcache_tags tags0 (
      .CLK       (CLK),
      .nRST      (nRST),
      .index     (tag_index),
      .tag       (req_tag),
      .hit       (hit),
      .hit_way   (hit_way),
      .lru_way   (lru_way),
      .sel_way   (sel_way),
      .sel_tag   (sel_tag),
      .sel_valid (sel_valid),
      .sel_dirty (sel_dirty),
      .tag_we    (tag_we),
      .new_valid (new_valid),
      .new_dirty (new_dirty),
      .lru_we    (lru_we),
      .new_lru   (new_lru)
   );

   // same set index as the tag store
   dcache_data data0 (
      .CLK      (CLK),
      .index    (tag_index),
      .way      (data_way),
      .word_sel (word_sel),
      .we       (data_we),
      .wdata    (data_wdata),
      .rdata    (data_rdata)
   );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# compile the cache and its testbench with Verilator, run, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_dcache -f dcache_top.f -o sim_dcache \
   && ./obj_dir/sim_dcache | tee /dev/stderr \
   | grep -qF "Simulation completed successfully" \
   && echo "run_sim: PASS" \
   || { echo "run_sim: FAIL"; exit 1; }

//--- testbench/dcache_checker.sv
module dcache_checker (
   input logic              CLK,
   input logic              nRST,
   input logic              dhit,
   input logic              flushed,
   input logic              mem_ren,
   input logic              mem_wen,
   input logic              mem_wait,
   input dcache_pkg::word_t mem_addr,
   input dcache_pkg::word_t mem_store
);
   timeunit 1ns;
   timeprecision 100ps;

   // one memory port, read and write never together
   a_one_request: assert property (@(posedge CLK) disable iff (!nRST)
      !(mem_ren && mem_wen))
      else $error("mem_ren and mem_wen high in the same cycle");

   // a waiting request keeps its command, address and data
   a_hold_on_wait: assert property (@(posedge CLK) disable iff (!nRST)
      (mem_ren || mem_wen) && mem_wait |=> $stable(mem_ren) && $stable(mem_wen)
      && $stable(mem_addr) && $stable(mem_store))
      else $error("memory request changed while mem_wait was high");

   // once halted the cache answers nothing
   a_no_hit_when_flushed: assert property (@(posedge CLK) disable iff (!nRST)
      !(dhit && flushed))
      else $error("dhit and flushed high together");

   // checked while reset is held, so no disable here
   a_quiet_in_reset: assert property (@(posedge CLK)
      !nRST |-> !(dhit || flushed || mem_ren || mem_wen))
      else $error("control output high during reset");

endmodule

//--- testbench/tb_dcache.sv
module tb_dcache;
   timeunit 1ns;
   timeprecision 100ps;

   import dcache_pkg::*;

   localparam int CLK_PERIOD    = 4;
   localparam int RESET_CYCLES  = 8;
   localparam int N_RESET_READS = 24;
   localparam int N_RANDOM      = 400;
   localparam int N_LRU         = 4;
   // one step per flush slot plus the reads after halt
   localparam int N_HALT        = FLUSH_SLOTS + 8;
   // cycles allowed per operation since a dirty miss is four stretched transfers
   localparam int OP_BOUND      = 64;
   localparam int WATCHDOG_NS   =
      (RESET_CYCLES + N_RESET_READS + N_RANDOM + N_LRU + N_HALT) * OP_BOUND * CLK_PERIOD;

   logic  CLK;
   logic  nRST;
   logic  dmem_ren;
   logic  dmem_wen;
   logic  halt;
   word_t dmem_addr;
   word_t dmem_store;
   word_t dmem_load;
   logic  dhit;
   logic  flushed;
   logic  mem_ren;
   logic  mem_wen;
   word_t mem_addr;
   word_t mem_store;
   word_t mem_load;
   logic  mem_wait;

   // word-addressed backing memory and flat reference model
   word_t backing [256];
   word_t model [256];

   int    seed = 32'h36e3_caf9;
   int    errors;
   int    checks;
   int    test_errors;
   int    test_checks;
   int    tests_run;
   int    tests_bad;
   // first write-back address seen while watching
   logic  watch_wen;
   logic  wen_seen;
   word_t first_wen_addr;

   dcache_top dut0 (.*);

   bind dcache_top dcache_checker chk0 (
      .CLK       (CLK),
      .nRST      (nRST),
      .dhit      (dhit),
      .flushed   (flushed),
      .mem_ren   (mem_ren),
      .mem_wen   (mem_wen),
      .mem_wait  (mem_wait),
      .mem_addr  (mem_addr),
      .mem_store (mem_store)
   );

   initial CLK = 1'b0;
   always #(CLK_PERIOD / 2) CLK = ~CLK;

   // preload pattern uses every bit of the word address
   function automatic word_t preload(int w);
      logic [7:0] a;
      a = 8'(w);
      return {8'hd0, a, ~a, a ^ 8'h3c};
   endfunction

   // four tags per set keeps evictions frequent
   function automatic word_t rand_addr();
      word_t a;
      a      = '0;
      a[7:6] = 2'($random(seed));
      a[5:3] = 3'($random(seed));
      a[2]   = 1'($random(seed));
      return a;
   endfunction

   task automatic check(input string name, input word_t addr, input word_t exp,
                        input word_t act);
      checks++;
      test_checks++;
      if (act !== exp)
      begin
         errors++;
         test_errors++;
         $display("[ERROR] %s addr %h: expected %h, actual %h", name, addr, exp, act);
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (test_errors == 0)
      begin
         $display("test %s: ok, %0d checks", name, test_checks);
      end
      else
      begin
         tests_bad++;
         $display("test %s: %0d of %0d checks wrong", name, test_errors, test_checks);
      end
      test_errors = 0;
      test_checks = 0;
   endtask

   // memory side for one cycle just after the falling edge
   task automatic settle();
      int wa;
      mem_wait = (($random(seed) & 3) == 0);
      #1;
      // request outputs are settled here until the rising edge
      wa       = int'(mem_addr[9:2]);
      // read data only while a read is requested
      mem_load = mem_ren ? backing[wa] : '0;
      if (watch_wen && mem_wen && !wen_seen)
      begin
         wen_seen       = 1'b1;
         first_wen_addr = mem_addr;
      end
      // write lands at the coming edge
      if (mem_wen && !mem_wait)
      begin
         backing[wa] = mem_store;
      end
   endtask

   // one processor access held until dhit
   task automatic access(input string name, input logic wr, input word_t addr,
                         input word_t wdata);
      int   wa;
      logic done;
      wa   = int'(addr[9:2]);
      done = 1'b0;
      @(negedge CLK);
      dmem_ren   = ~wr;
      dmem_wen   = wr;
      dmem_addr  = addr;
      dmem_store = wdata;
      while (!done)
      begin
         settle();
         if (dhit)
         begin
            done = 1'b1;
            if (wr)
            begin
               model[wa] = wdata;
            end
            else
            begin
               check(name, addr, model[wa], dmem_load);
            end
         end
         else
         begin
            @(negedge CLK);
         end
      end
   endtask

   initial
   begin
      word_t a_addr;
      word_t b_addr;
      word_t c_addr;
      nRST       = 1'b0;
      dmem_ren   = 1'b0;
      dmem_wen   = 1'b0;
      halt       = 1'b0;
      dmem_addr  = '0;
      dmem_store = '0;
      mem_load   = '0;
      mem_wait   = 1'b0;
      watch_wen  = 1'b0;
      wen_seen   = 1'b0;
      errors     = 0;
      checks     = 0;
      test_errors = 0;
      test_checks = 0;
      tests_run  = 0;
      tests_bad  = 0;
      for (int w = 0; w < 256; w++)
      begin
         backing[w] = preload(w);
         model[w]   = preload(w);
      end
      repeat (RESET_CYCLES) @(negedge CLK);
      nRST = 1'b1;

      // cold cache so every read comes from the preload
      for (int i = 0; i < N_RESET_READS; i++)
      begin
         access("reset_reads", 1'b0, rand_addr(), '0);
      end
      end_test("reset_reads");

      // mixed traffic with roughly half writes
      for (int i = 0; i < N_RANDOM; i++)
      begin
         access("random_mix", 1'($random(seed)), rand_addr(), $random(seed));
      end
      end_test("random_mix");

      // three blocks of set 5 with tags unused so far
      a_addr = {22'd0, 4'd4, 3'd5, 3'b000};
      b_addr = {22'd0, 4'd5, 3'd5, 3'b000};
      c_addr = {22'd0, 4'd6, 3'd5, 3'b000};
      access("lru", 1'b1, a_addr, 32'haaaa_0001);
      access("lru", 1'b1, b_addr, 32'hbbbb_0002);
      access("lru", 1'b0, a_addr, '0);
      // B is now least recently used and dirty
      wen_seen  = 1'b0;
      watch_wen = 1'b1;
      access("lru", 1'b0, c_addr, '0);
      watch_wen = 1'b0;
      if (!wen_seen)
      begin
         errors++;
         test_errors++;
         $display("[ERROR] lru: reading C evicted no dirty block, no memory write seen");
      end
      else
      begin
         check("lru", c_addr, b_addr, first_wen_addr);
      end
      end_test("lru");

      // halt with no request pending
      @(negedge CLK);
      dmem_ren = 1'b0;
      dmem_wen = 1'b0;
      halt     = 1'b1;
      settle();
      while (!flushed)
      begin
         @(negedge CLK);
         settle();
      end
      // requests after the flush get no answer
      for (int i = 0; i < 8; i++)
      begin
         @(negedge CLK);
         dmem_ren  = 1'b1;
         dmem_addr = rand_addr();
         settle();
         check("halt_flushed", dmem_addr, 32'd1, {31'd0, flushed});
         check("halt_dhit", dmem_addr, 32'd0, {31'd0, dhit});
      end
      for (int w = 0; w < 256; w++)
      begin
         check("halt_memory", word_t'(w) << 2, model[w], backing[w]);
      end
      end_test("halt");

      $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
               tests_run, tests_bad, checks, errors);
      if (errors == 0)
      begin
         $display("Simulation completed successfully");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

   // bound from the operation count so a stuck handshake ends the run
   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog: run still going after %0d ns, cache or memory stuck", WATCHDOG_NS);
      $display("Simulation failed");
      $finish;
   end

endmodule
